// File: sim.f
common/dram_arb_pkg.sv
common/mem_ui_if.sv
arbiter/arb_ctrl.sv
arbiter/arb_port_mux.sv
logic/dram_arbiter.sv
test/dram_arbiter_assert.sv
test/tb_dram_arbiter.sv

// File: Makefile
TOP := tb_dram_arbiter

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// File: test/tb_dram_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dram_arbiter;

   localparam int NUM_STEPS = 18;

   typedef struct packed {
      logic                     s0_en;
      logic                     s1_en;
      logic                     ovr_en;
      logic                     ovr_sel;
      int                       hold;           // edges that sample this row
      dram_arb_pkg::arb_state_t exp_state;      // after the last held edge
      logic                     exp_conflict;   // after the first held edge
      logic                     exp_owner;
   } step_t;

   logic                    clk, rst, override_en, arbiter_conflict;
   dram_arb_pkg::port_sel_t override_sel;
   logic [3:0]              arbiter_state;
   dram_arb_pkg::addr_t     master_addr, slave0_addr, slave1_addr;
   dram_arb_pkg::cmd_t      master_cmd, slave0_cmd, slave1_cmd;
   dram_arb_pkg::data_t     master_wdf_data, slave0_wdf_data, slave1_wdf_data;
   dram_arb_pkg::data_t     master_rd_data, slave0_rd_data, slave1_rd_data;
   dram_arb_pkg::mask_t     master_wdf_mask, slave0_wdf_mask, slave1_wdf_mask;
   logic                    master_en, master_wdf_end, master_wdf_wren;
   logic                    master_rd_data_end, master_rd_data_valid, master_rdy, master_wdf_rdy;
   logic                    slave0_en, slave0_wdf_end, slave0_wdf_wren;
   logic                    slave0_rd_data_end, slave0_rd_data_valid, slave0_rdy, slave0_wdf_rdy;
   logic                    slave1_en, slave1_wdf_end, slave1_wdf_wren;
   logic                    slave1_rd_data_end, slave1_rd_data_valid, slave1_rdy, slave1_wdf_rdy;

   step_t       steps [NUM_STEPS];
   logic        table_ready = 1'b0;
   logic [31:0] lfsr_state = 32'h6272c79c;
   int          errors = 0;
   int          checks = 0;

   dram_arbiter #(.EXPIRE_CYCLES(8)) dram_arbiter_inst (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // fibonacci form, taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic dram_arb_pkg::data_t random_bits(input int n);
      dram_arb_pkg::data_t value;
      value = '0;
      for (int b = 0; b < n; b++) begin
         value = {value[286:0], lfsr_bit()};
      end
      return value;
   endfunction

   task automatic refresh_data();
      slave0_addr          <= 32'(random_bits(32));
      slave0_cmd           <= 3'(random_bits(3));
      slave0_wdf_data      <= random_bits(288);
      slave0_wdf_mask      <= 36'(random_bits(36));
      slave0_wdf_end       <= lfsr_bit();
      slave0_wdf_wren      <= lfsr_bit();
      slave1_addr          <= 32'(random_bits(32));
      slave1_cmd           <= 3'(random_bits(3));
      slave1_wdf_data      <= random_bits(288);
      slave1_wdf_mask      <= 36'(random_bits(36));
      slave1_wdf_end       <= lfsr_bit();
      slave1_wdf_wren      <= lfsr_bit();
      master_rd_data       <= random_bits(288);
      master_rd_data_end   <= lfsr_bit();
      master_rd_data_valid <= lfsr_bit();
      master_rdy           <= lfsr_bit();
      master_wdf_rdy       <= lfsr_bit();
   endtask

   task automatic drive_step(input int idx);
      if (idx < NUM_STEPS) begin
         slave0_en    <= steps[idx].s0_en;
         slave1_en    <= steps[idx].s1_en;
         override_en  <= steps[idx].ovr_en;
         override_sel <= steps[idx].ovr_sel;
      end else begin              // idle requesters
         slave0_en    <= 1'b0;
         slave1_en    <= 1'b0;
         override_en  <= 1'b0;
         override_sel <= 1'b0;
      end
      refresh_data();
   endtask

   task automatic load_table();
      // s0_en, s1_en, ovr_en, ovr_sel, hold, state, conflict, owner
      steps[0]  = '{1'b0, 1'b0, 1'b0, 1'b0, 2, dram_arb_pkg::ARB_WAIT, 1'b0, 1'b0};
      steps[1]  = '{1'b1, 1'b1, 1'b0, 1'b0, 1, dram_arb_pkg::ARB_PORT0, 1'b1, 1'b0};
      steps[2]  = '{1'b1, 1'b0, 1'b0, 1'b0, 1, dram_arb_pkg::ARB_PORT0, 1'b0, 1'b0};
      steps[3]  = '{1'b0, 1'b0, 1'b0, 1'b0, 7, dram_arb_pkg::ARB_PORT0, 1'b0, 1'b0};
      steps[4]  = '{1'b0, 1'b0, 1'b0, 1'b0, 1, dram_arb_pkg::ARB_WAIT, 1'b0, 1'b0};
      steps[5]  = '{1'b0, 1'b1, 1'b0, 1'b0, 1, dram_arb_pkg::ARB_PORT1, 1'b0, 1'b1};
      steps[6]  = '{1'b0, 1'b1, 1'b0, 1'b0, 3, dram_arb_pkg::ARB_PORT1, 1'b0, 1'b1};
      steps[7]  = '{1'b1, 1'b1, 1'b0, 1'b0, 1, dram_arb_pkg::ARB_PORT0, 1'b0, 1'b0};
      steps[8]  = '{1'b1, 1'b1, 1'b0, 1'b0, 1, dram_arb_pkg::ARB_PORT0, 1'b1, 1'b0};
      steps[9]  = '{1'b0, 1'b0, 1'b0, 1'b0, 8, dram_arb_pkg::ARB_WAIT, 1'b0, 1'b0};
      steps[10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1, dram_arb_pkg::ARB_PORT1, 1'b0, 1'b1};
      steps[11] = '{1'b0, 1'b0, 1'b0, 1'b0, 7, dram_arb_pkg::ARB_PORT1, 1'b0, 1'b1};
      steps[12] = '{1'b0, 1'b0, 1'b0, 1'b0, 1, dram_arb_pkg::ARB_WAIT, 1'b0, 1'b0};
      steps[13] = '{1'b1, 1'b0, 1'b1, 1'b1, 1, dram_arb_pkg::ARB_OVERRIDE, 1'b0, 1'b1};
      steps[14] = '{1'b1, 1'b1, 1'b1, 1'b1, 2, dram_arb_pkg::ARB_OVERRIDE, 1'b0, 1'b1};
      steps[15] = '{1'b1, 1'b1, 1'b1, 1'b0, 1, dram_arb_pkg::ARB_OVERRIDE, 1'b0, 1'b0};
      steps[16] = '{1'b0, 1'b0, 1'b0, 1'b0, 1, dram_arb_pkg::ARB_WAIT, 1'b0, 1'b0};
      steps[17] = '{1'b0, 1'b0, 1'b0, 1'b0, 2, dram_arb_pkg::ARB_WAIT, 1'b0, 1'b0};
   endtask

   task automatic compare_value(input string name, input dram_arb_pkg::data_t expected,
                                input dram_arb_pkg::data_t actual);
      checks++;
      assert (actual === expected) else begin
         $display("error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
         errors++;
      end
   endtask

   // owner sees the controller, the other port sees zeros
   task automatic verify_owner(input logic owner);
      compare_value("master_addr", 288'(owner ? slave1_addr : slave0_addr), 288'(master_addr));
      compare_value("master_cmd", 288'(owner ? slave1_cmd : slave0_cmd), 288'(master_cmd));
      compare_value("master_en", 288'(owner ? slave1_en : slave0_en), 288'(master_en));
      compare_value("master_wdf_data", owner ? slave1_wdf_data : slave0_wdf_data,
                    master_wdf_data);
      compare_value("master_wdf_end", 288'(owner ? slave1_wdf_end : slave0_wdf_end),
                    288'(master_wdf_end));
      compare_value("master_wdf_mask", 288'(owner ? slave1_wdf_mask : slave0_wdf_mask),
                    288'(master_wdf_mask));
      compare_value("master_wdf_wren", 288'(owner ? slave1_wdf_wren : slave0_wdf_wren),
                    288'(master_wdf_wren));
      compare_value("slave0_rd_data", owner ? '0 : master_rd_data, slave0_rd_data);
      compare_value("slave1_rd_data", owner ? master_rd_data : '0, slave1_rd_data);
      compare_value("slave0_rd_data_end", 288'(owner ? 1'b0 : master_rd_data_end),
                    288'(slave0_rd_data_end));
      compare_value("slave1_rd_data_end", 288'(owner ? master_rd_data_end : 1'b0),
                    288'(slave1_rd_data_end));
      compare_value("slave0_rd_data_valid", 288'(owner ? 1'b0 : master_rd_data_valid),
                    288'(slave0_rd_data_valid));
      compare_value("slave1_rd_data_valid", 288'(owner ? master_rd_data_valid : 1'b0),
                    288'(slave1_rd_data_valid));
      compare_value("slave0_rdy", 288'(owner ? 1'b0 : master_rdy), 288'(slave0_rdy));
      compare_value("slave1_rdy", 288'(owner ? master_rdy : 1'b0), 288'(slave1_rdy));
      compare_value("slave0_wdf_rdy", 288'(owner ? 1'b0 : master_wdf_rdy),
                    288'(slave0_wdf_rdy));
      compare_value("slave1_wdf_rdy", 288'(owner ? master_wdf_rdy : 1'b0),
                    288'(slave1_wdf_rdy));
   endtask

   initial begin
      int total;
      total = 0;
      wait (table_ready);
      foreach (steps[i]) total += steps[i].hold;
      #((total + 50) * 20);
      $display("timeout: the step table did not finish within %0d clock cycles", total + 50);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      rst <= 1'b1;
      drive_step(NUM_STEPS);
      load_table();
      table_ready = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      compare_value("master_addr", '0, 288'(master_addr));   // mux forced low in reset
      compare_value("slave0_rd_data", '0, slave0_rd_data);
      compare_value("slave1_rd_data", '0, slave1_rd_data);
      compare_value("slave0_rdy", '0, 288'(slave0_rdy));
      compare_value("slave1_wdf_rdy", '0, 288'(slave1_wdf_rdy));
      @(posedge clk);
      rst <= 1'b0;
      drive_step(0);
      for (int i = 0; i < NUM_STEPS; i++) begin
         for (int c = 1; c <= steps[i].hold; c++) begin
            @(posedge clk);
            if (c == steps[i].hold) begin
               drive_step(i + 1);   // last sampling edge of this row
            end
            @(negedge clk);
            if (c == 1) begin
               compare_value("arbiter_conflict", 288'(steps[i].exp_conflict),
                             288'(arbiter_conflict));
            end
         end
         compare_value("arbiter_state", 288'(steps[i].exp_state), 288'(arbiter_state));
         verify_owner(steps[i].exp_owner);
         $display("step %0d finished, %0d errors so far", i, errors);
      end
      $display("%0d steps, %0d checks, %0d errors", NUM_STEPS, checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: test/dram_arbiter_assert.sv
`timescale 1ns/1ns
`default_nettype none

module dram_arbiter_assert (
   input wire                            clk,
   input wire                            rst,
   input wire                            req0_en,
   input wire                            req1_en,
   input wire                            conflict,
   input wire dram_arb_pkg::port_sel_t   sel,
   input var  dram_arb_pkg::arb_state_t  state
);

   logic cause;   // losing requester asks at this edge

   assign cause = ((state == dram_arb_pkg::ARB_WAIT) && req0_en && req1_en) ||
                  ((state == dram_arb_pkg::ARB_PORT0) && req1_en);

   state_legal: assert property (@(posedge clk) disable iff (rst)
      state inside {dram_arb_pkg::ARB_WAIT, dram_arb_pkg::ARB_PORT0,
                    dram_arb_pkg::ARB_PORT1, dram_arb_pkg::ARB_OVERRIDE})
      else $error("arbiter state outside the FSM encoding");

   conflict_pulse: assert property (@(posedge clk) disable iff (rst)
      conflict && !cause |=> !conflict)
      else $error("conflict stayed high without a new cause");

   sel_owner: assert property (@(posedge clk) disable iff (rst)
      sel == 1'b1 |-> state inside {dram_arb_pkg::ARB_PORT1, dram_arb_pkg::ARB_OVERRIDE})
      else $error("port 1 selected outside PORT1 and OVERRIDE");

endmodule

bind arb_ctrl dram_arbiter_assert arb_assert_inst (
   .clk      (clk),
   .rst      (rst),
   .req0_en  (req0_en),
   .req1_en  (req1_en),
   .conflict (conflict),
   .sel      (sel),
   .state    (state)
);

`default_nettype wire

// File: logic/dram_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module dram_arbiter #(
   parameter int EXPIRE_CYCLES = dram_arb_pkg::EXPIRE_CYCLES_DEFAULT
) (
   input  wire                          clk,
   input  wire                          rst,

   // software monitor and override
   input  wire                          override_en,
   input  wire dram_arb_pkg::port_sel_t override_sel,
   output logic [3:0]                   arbiter_state,
   output logic                         arbiter_conflict,

   // toward the DDR3 controller
   input  wire dram_arb_pkg::data_t     master_rd_data,
   input  wire                          master_rd_data_end,
   input  wire                          master_rd_data_valid,
   input  wire                          master_rdy,
   input  wire                          master_wdf_rdy,
   output dram_arb_pkg::addr_t          master_addr,
   output dram_arb_pkg::cmd_t           master_cmd,
   output logic                         master_en,
   output dram_arb_pkg::data_t          master_wdf_data,
   output logic                         master_wdf_end,
   output dram_arb_pkg::mask_t          master_wdf_mask,
   output logic                         master_wdf_wren,

   // fabric requester, fixed priority
   output dram_arb_pkg::data_t          slave0_rd_data,
   output logic                         slave0_rd_data_end,
   output logic                         slave0_rd_data_valid,
   output logic                         slave0_rdy,
   output logic                         slave0_wdf_rdy,
   input  wire dram_arb_pkg::addr_t     slave0_addr,
   input  wire dram_arb_pkg::cmd_t      slave0_cmd,
   input  wire                          slave0_en,
   input  wire dram_arb_pkg::data_t     slave0_wdf_data,
   input  wire                          slave0_wdf_end,
   input  wire dram_arb_pkg::mask_t     slave0_wdf_mask,
   input  wire                          slave0_wdf_wren,

   // CPU requester
   output dram_arb_pkg::data_t          slave1_rd_data,
   output logic                         slave1_rd_data_end,
   output logic                         slave1_rd_data_valid,
   output logic                         slave1_rdy,
   output logic                         slave1_wdf_rdy,
   input  wire dram_arb_pkg::addr_t     slave1_addr,
   input  wire dram_arb_pkg::cmd_t      slave1_cmd,
   input  wire                          slave1_en,
   input  wire dram_arb_pkg::data_t     slave1_wdf_data,
   input  wire                          slave1_wdf_end,
   input  wire dram_arb_pkg::mask_t     slave1_wdf_mask,
   input  wire                          slave1_wdf_wren
);

   dram_arb_pkg::port_sel_t  sel;
   dram_arb_pkg::arb_state_t state;

   mem_ui_if p0_if ();
   mem_ui_if p1_if ();
   mem_ui_if ctl_if ();

   assign p0_if.addr           = slave0_addr;
   assign p0_if.cmd            = slave0_cmd;
   assign p0_if.en             = slave0_en;
   assign p0_if.wdf_data       = slave0_wdf_data;
   assign p0_if.wdf_end        = slave0_wdf_end;
   assign p0_if.wdf_mask       = slave0_wdf_mask;
   assign p0_if.wdf_wren       = slave0_wdf_wren;
   assign slave0_rd_data       = p0_if.rd_data;
   assign slave0_rd_data_end   = p0_if.rd_data_end;
   assign slave0_rd_data_valid = p0_if.rd_data_valid;
   assign slave0_rdy           = p0_if.rdy;
   assign slave0_wdf_rdy       = p0_if.wdf_rdy;

   assign p1_if.addr           = slave1_addr;
   assign p1_if.cmd            = slave1_cmd;
   assign p1_if.en             = slave1_en;
   assign p1_if.wdf_data       = slave1_wdf_data;
   assign p1_if.wdf_end        = slave1_wdf_end;
   assign p1_if.wdf_mask       = slave1_wdf_mask;
   assign p1_if.wdf_wren       = slave1_wdf_wren;
   assign slave1_rd_data       = p1_if.rd_data;
   assign slave1_rd_data_end   = p1_if.rd_data_end;
   assign slave1_rd_data_valid = p1_if.rd_data_valid;
   assign slave1_rdy           = p1_if.rdy;
   assign slave1_wdf_rdy       = p1_if.wdf_rdy;

   // controller responses in, selected command out
   assign ctl_if.rd_data       = master_rd_data;
   assign ctl_if.rd_data_end   = master_rd_data_end;
   assign ctl_if.rd_data_valid = master_rd_data_valid;
   assign ctl_if.rdy           = master_rdy;
   assign ctl_if.wdf_rdy       = master_wdf_rdy;
   assign master_addr          = ctl_if.addr;
   assign master_cmd           = ctl_if.cmd;
   assign master_en            = ctl_if.en;
   assign master_wdf_data      = ctl_if.wdf_data;
   assign master_wdf_end       = ctl_if.wdf_end;
   assign master_wdf_mask      = ctl_if.wdf_mask;
   assign master_wdf_wren      = ctl_if.wdf_wren;

   assign arbiter_state        = state;   // raw enum encoding

   arb_ctrl #(
      .EXPIRE_CYCLES (EXPIRE_CYCLES)
   ) arb_ctrl_inst (
      .clk          (clk),
      .rst          (rst),
      .req0_en      (slave0_en),
      .req1_en      (slave1_en),
      .override_en  (override_en),
      .override_sel (override_sel),
      .sel          (sel),
      .state        (state),
      .conflict     (arbiter_conflict)
   );

   arb_port_mux arb_port_mux_inst (
      .rst (rst),
      .sel (sel),
      .p0  (p0_if.controller),
      .p1  (p1_if.controller),
      .ctl (ctl_if.requester)
   );

endmodule

`default_nettype wire

// File: arbiter/arb_port_mux.sv
`timescale 1ns/1ns
`default_nettype none

module arb_port_mux (
   input  wire                          rst,
   input  wire dram_arb_pkg::port_sel_t sel,
   mem_ui_if.controller                 p0,
   mem_ui_if.controller                 p1,
   mem_ui_if.requester                  ctl
);

   always_comb begin
      // everything idles at zero, the owner overrides below
      ctl.addr          = '0;
      ctl.cmd           = '0;
      ctl.en            = 1'b0;
      ctl.wdf_data      = '0;
      ctl.wdf_end       = 1'b0;
      ctl.wdf_mask      = '0;
      ctl.wdf_wren      = 1'b0;

      p0.rd_data        = '0;
      p0.rd_data_end    = 1'b0;
      p0.rd_data_valid  = 1'b0;
      p0.rdy            = 1'b0;
      p0.wdf_rdy        = 1'b0;

      p1.rd_data        = '0;
      p1.rd_data_end    = 1'b0;
      p1.rd_data_valid  = 1'b0;
      p1.rdy            = 1'b0;
      p1.wdf_rdy        = 1'b0;

      if (!rst) begin
         if (sel == 1'b0) begin     // fabric port owns the controller
            ctl.addr         = p0.addr;
            ctl.cmd          = p0.cmd;
            ctl.en           = p0.en;
            ctl.wdf_data     = p0.wdf_data;
            ctl.wdf_end      = p0.wdf_end;
            ctl.wdf_mask     = p0.wdf_mask;
            ctl.wdf_wren     = p0.wdf_wren;
            p0.rd_data       = ctl.rd_data;
            p0.rd_data_end   = ctl.rd_data_end;
            p0.rd_data_valid = ctl.rd_data_valid;
            p0.rdy           = ctl.rdy;
            p0.wdf_rdy       = ctl.wdf_rdy;
         end else begin             // CPU port
            ctl.addr         = p1.addr;
            ctl.cmd          = p1.cmd;
            ctl.en           = p1.en;
            ctl.wdf_data     = p1.wdf_data;
            ctl.wdf_end      = p1.wdf_end;
            ctl.wdf_mask     = p1.wdf_mask;
            ctl.wdf_wren     = p1.wdf_wren;
            p1.rd_data       = ctl.rd_data;
            p1.rd_data_end   = ctl.rd_data_end;
            p1.rd_data_valid = ctl.rd_data_valid;
            p1.rdy           = ctl.rdy;
            p1.wdf_rdy       = ctl.wdf_rdy;
         end
      end
   end

endmodule

`default_nettype wire

// File: arbiter/arb_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module arb_ctrl #(
   parameter int EXPIRE_CYCLES = dram_arb_pkg::EXPIRE_CYCLES_DEFAULT
) (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          req0_en,
   input  wire                          req1_en,
   input  wire                          override_en,
   input  wire dram_arb_pkg::port_sel_t override_sel,
   output dram_arb_pkg::port_sel_t      sel,
   output dram_arb_pkg::arb_state_t     state,
   output logic                         conflict
);

   localparam int CNT_W = (EXPIRE_CYCLES > 1) ? $clog2(EXPIRE_CYCLES) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(EXPIRE_CYCLES - 1);

   dram_arb_pkg::arb_state_t state_next;
   dram_arb_pkg::port_sel_t  sel_next;
   logic [CNT_W-1:0]         idle_cnt;
   logic [CNT_W-1:0]         idle_cnt_next;
   logic                     owner_en;
   logic                     expired;
   logic                     conflict_next;

   // en of whoever holds the port, only meaningful in PORT0/PORT1
   assign owner_en = (state == dram_arb_pkg::ARB_PORT1) ? req1_en : req0_en;

   // this edge is idle cycle number EXPIRE_CYCLES
   assign expired = !owner_en && (idle_cnt == CNT_LAST);

   always_comb begin
      state_next    = state;
      idle_cnt_next = '0;     // cleared unless an owner sits idle
      case (state)
         dram_arb_pkg::ARB_WAIT: begin
            if (override_en) begin
               state_next = dram_arb_pkg::ARB_OVERRIDE;
            end else if (req0_en) begin
               state_next = dram_arb_pkg::ARB_PORT0;     // fabric wins ties
            end else if (req1_en) begin
               state_next = dram_arb_pkg::ARB_PORT1;
            end
         end
         dram_arb_pkg::ARB_PORT0: begin
            if (expired) begin
               state_next = dram_arb_pkg::ARB_WAIT;
            end else if (!owner_en) begin
               idle_cnt_next = idle_cnt + 1'b1;
            end
         end
         dram_arb_pkg::ARB_PORT1: begin
            // fabric preempts the CPU, counter restarts from zero
            if (req0_en) begin
               state_next = dram_arb_pkg::ARB_PORT0;
            end else if (expired) begin
               state_next = dram_arb_pkg::ARB_WAIT;
            end else if (!owner_en) begin
               idle_cnt_next = idle_cnt + 1'b1;
            end
         end
         dram_arb_pkg::ARB_OVERRIDE: begin
            if (!override_en) begin
               state_next = dram_arb_pkg::ARB_WAIT;
            end
         end
         default: begin
            state_next = dram_arb_pkg::ARB_WAIT;
         end
      endcase
   end

   // select follows the state it is registered with
   always_comb begin
      case (state_next)
         dram_arb_pkg::ARB_PORT1:    sel_next = 1'b1;
         dram_arb_pkg::ARB_OVERRIDE: sel_next = override_sel;  // resampled every cycle
         default:                    sel_next = 1'b0;
      endcase
   end

   // losing requester was asking while the other one holds or wins the port
   assign conflict_next = ((state == dram_arb_pkg::ARB_WAIT) && req0_en && req1_en) ||
                          ((state == dram_arb_pkg::ARB_PORT0) && req1_en);

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= dram_arb_pkg::ARB_WAIT;
         sel      <= 1'b0;
         conflict <= 1'b0;
         idle_cnt <= '0;
      end else begin
         state    <= state_next;
         sel      <= sel_next;
         conflict <= conflict_next;   // one cycle pulse per cause
         idle_cnt <= idle_cnt_next;
      end
   end

endmodule

`default_nettype wire

// File: common/mem_ui_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_ui_if;

   // command and write data, from the requester
   dram_arb_pkg::addr_t addr;
   dram_arb_pkg::cmd_t  cmd;
   logic                en;
   dram_arb_pkg::data_t wdf_data;
   logic                wdf_end;
   dram_arb_pkg::mask_t wdf_mask;
   logic                wdf_wren;

   // responses, from the controller
   dram_arb_pkg::data_t rd_data;
   logic                rd_data_end;
   logic                rd_data_valid;
   logic                rdy;
   logic                wdf_rdy;

   modport requester (
      output addr, cmd, en, wdf_data, wdf_end, wdf_mask, wdf_wren,
      input  rd_data, rd_data_end, rd_data_valid, rdy, wdf_rdy
   );

   modport controller (
      input  addr, cmd, en, wdf_data, wdf_end, wdf_mask, wdf_wren,
      output rd_data, rd_data_end, rd_data_valid, rdy, wdf_rdy
   );

endinterface

`default_nettype wire

// File: common/dram_arb_pkg.sv
`default_nettype none

package dram_arb_pkg;

   // widths fixed by the DDR3 controller user interface
   typedef logic [31:0]  addr_t;    // command address
   typedef logic [2:0]   cmd_t;     // controller command code
   typedef logic [287:0] data_t;    // one read or write burst
   typedef logic [35:0]  mask_t;    // write byte mask, one bit per byte

   // which requester owns the controller
   // 0 is the fabric port, 1 is the CPU port
   typedef logic [0:0] port_sel_t;

   // ownership FSM, encoding is seen on arbiter_state
   typedef enum logic [3:0] {
      ARB_WAIT     = 4'd0,
      ARB_PORT0    = 4'd1,
      ARB_PORT1    = 4'd2,
      ARB_OVERRIDE = 4'd3
   } arb_state_t;

   // idle cycles before the owner loses the port
   localparam int EXPIRE_CYCLES_DEFAULT = 128;

endpackage

`default_nettype wire
